/* mic_stimulus.txt */
// left_sample right_sample expected_display, all hex
// display shows bits 22..11 of the left magnitude
3456ab 000000 68a
000000 7fffff 000
7fffff 000000 fff
800000 000000 fff
cba955 000000 68a
001000 7fffff 002
fffffe 000000 000
400000 000000 800
c00000 7fffff 800
0007ff 000000 000
000800 000000 001
800001 000000 fff
012345 000000 024
123456 800000 246

/* mic_meter.f */
board_pkg.sv
audio_pkg.sv
slow_clk_gen.sv
inmp441_mic_i2s_receiver.sv
seven_segment_display.sv
lab_top.sv
board_specific_top.sv
board_mic_checker.sv
tb_board_top.sv

/* Makefile */
SIM      = verilator
VFLAGS   = --binary --assert -j 0
TOP      = tb_board_top
FILELIST = mic_meter.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard *.sv)
LOG      = sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) mic_stimulus.txt
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_board_top.sv */
`timescale 1ns/100ps

module tb_board_top
    import board_pkg::*, audio_pkg::*;
;

    localparam int n_cases        = 14;
    localparam int half_window    = 2000;   // 1 MHz clk, 250 Hz slow clock
    localparam int timeout_cycles = n_cases * 3 * 2 * half_window + 10000;

    logic                      clk;
    logic                      key;
    wire                       led;
    wire  [7:0]                abcdefgh_n;
    wire  [w_digit - 1:0]      digit_n;
    wire  [w_gpio + 3 - 1:3]   gpio;

    logic                      sd_drv = 1'b0;
    logic [w_sample - 1:0]     stim_mem [0:3 * n_cases - 1];
    logic [w_sample - 1:0]     cur_left;
    logic [w_sample - 1:0]     cur_right;
    logic [w_meter - 1:0]      exp_disp;
    logic                      check_on;
    logic [w_digit - 1:0]      seen;
    int                        err_count   = 0;
    int                        check_count = 0;

    // mic model state
    logic                      sck_last;
    logic                      ws_last;
    int                        bit_pos;

    // LED monitor state
    int                        cycle      = 0;
    int                        edge_cycle = 0;
    logic                      released   = 1'b0;
    logic                      led_last   = 1'b0;

    assign gpio[pin_sd] = sd_drv;

    board_specific_top
    #(
        .clk_mhz     ( 1   ),
        .slow_clk_hz ( 250 )
    )
    i_dut
    (
        .CLK        ( clk        ),
        .KEY        ( key        ),
        .LED        ( led        ),
        .ABCDEFGH_N ( abcdefgh_n ),
        .DIGIT_N    ( digit_n    ),
        .GPIO_J12   ( gpio       )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checks: %0d, errors: %0d", check_count, err_count);
    endtask

    task automatic check_digits_lit(input string phase);
        for (int k = 0; k < w_digit; k++) begin
            if (!seen[k]) begin
                err_count++;
                $display("ERROR: digit %0d never lit during %s", k, phase);
            end
        end
    endtask

    // display reading for a left sample: magnitude, 800000 clips
    function automatic logic [w_meter - 1:0] expected_display(input logic [w_sample - 1:0] left);
        logic [w_sample - 1:0] mag;
        if (left == 24'h800000)
            mag = mag_max;
        else if (left[w_sample - 1])
            mag = -left;
        else
            mag = left;
        return mag[meter_msb:meter_lsb];
    endfunction

    // segments a..g then dot, bit 4 set for an unknown pattern
    function automatic logic [4:0] seg_to_hex(input logic [7:0] seg);
        case (seg)
            8'hfc: return 5'h0;
            8'h60: return 5'h1;
            8'hda: return 5'h2;
            8'hf2: return 5'h3;
            8'h66: return 5'h4;
            8'hb6: return 5'h5;
            8'hbe: return 5'h6;
            8'he0: return 5'h7;
            8'hfe: return 5'h8;
            8'hf6: return 5'h9;
            8'hee: return 5'ha;
            8'h3e: return 5'hb;
            8'h9c: return 5'hc;
            8'h7a: return 5'hd;
            8'h9e: return 5'he;
            8'h8e: return 5'hf;
            default: return 5'h10;
        endcase
    endfunction

    // INMP441 model, sd moves one clk after sck falls
    always @(posedge clk) begin
        if (!key) begin
            sck_last <= 1'b0;
            ws_last  <= 1'b0;
            bit_pos  <= 0;
            sd_drv   <= 1'b0;
        end else begin
            sck_last <= gpio[pin_sck];
            if (sck_last && !gpio[pin_sck]) begin
                ws_last <= gpio[pin_ws];
                if (gpio[pin_ws] != ws_last) begin
                    bit_pos <= 0;                  // MSB follows one sck later
                    sd_drv  <= 1'b0;
                end else begin
                    bit_pos <= bit_pos + 1;
                    if (bit_pos < w_sample)
                        sd_drv <= (!gpio[pin_ws] && !gpio[pin_lr]) ?
                                  cur_left[w_sample - 1 - bit_pos] :
                                  cur_right[w_sample - 1 - bit_pos];
                    else
                        sd_drv <= 1'b0;            // idle after the LSB
                end
            end
        end
    end

    always @(negedge clk) begin : decode_display
        logic [4:0] hex;
        int         idx;
        if (check_on && $countones(~digit_n) == 1) begin
            idx = 0;
            for (int k = 0; k < w_digit; k++)
                if (!digit_n[k])
                    idx = k;
            hex = seg_to_hex(~abcdefgh_n);
            if (hex[4]) begin
                err_count++;
                $display("ERROR: segment pattern %h on digit %0d is no hex digit",
                         ~abcdefgh_n, idx);
            end else begin
                check_value("disp_digit", 32'(hex[3:0]), 32'(exp_disp[idx * 4 +: 4]));
            end
            seen[idx] = 1'b1;
        end
    end

    always @(negedge clk) begin : watch_led
        cycle = cycle + 1;
        if (cycle > timeout_cycles) begin
            err_count++;
            $display("ERROR: timeout, run stopped after %0d cycles", cycle);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end else if (!key) begin
            check_value("LED", 32'(led), 32'(0));
        end else if (!released) begin
            released   = 1'b1;                     // first negedge after release
            edge_cycle = cycle;
            led_last   = led;
        end else if (led != led_last) begin
            check_value("led_interval", 32'(cycle - edge_cycle), 32'(half_window));
            edge_cycle = cycle;
            led_last   = led;
        end
    end

    initial begin
        logic [w_meter - 1:0] file_exp;
        key       = 1'b0;
        cur_left  = '0;
        cur_right = '0;
        exp_disp  = '0;
        seen      = '0;
        check_on  = 1'b1;                          // 000 from reset on
        $readmemh("mic_stimulus.txt", stim_mem);
        repeat (5) @(posedge clk);
        key <= 1'b1;
        @(posedge led);
        check_on = 1'b0;
        check_digits_lit("reset");

        for (int i = 0; i < n_cases; i++) begin
            cur_left  <= stim_mem[3 * i];
            cur_right <= stim_mem[3 * i + 1];
            file_exp  = stim_mem[3 * i + 2][w_meter - 1:0];
            exp_disp  = expected_display(stim_mem[3 * i]);
            check_value("stim_expect", 32'(exp_disp), 32'(file_exp));
            @(posedge led);
            @(posedge led);
            repeat (8) @(posedge clk);            // let the display register settle
            seen     = '0;
            check_on = 1'b1;
            repeat (6 * scan_cycles) @(posedge clk);
            check_on = 1'b0;
            check_digits_lit($sformatf("case %0d", i));
            @(posedge led);
        end

        print_counts();
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* board_mic_checker.sv */
`timescale 1ns/100ps

module board_mic_checker
    import audio_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic sck,
    input logic ws,
    input logic sample_valid
);

    int   since_valid;   // clk cycles after the last strobe
    logic have_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_valid <= 0;
            have_prev   <= 1'b0;
        end else if (sample_valid) begin
            since_valid <= 0;
            have_prev   <= 1'b1;
        end else begin
            since_valid <= since_valid + 1;
        end
    end

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(sck))
        else $error("ws changed in a cycle without a falling sck");

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid held longer than one cycle");

    // one strobe per 64 sck frame
    valid_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && have_prev |-> since_valid == frame_bits * 2 * sck_half - 1)
        else $error("sample_valid strobes not one frame apart");

endmodule

bind inmp441_mic_i2s_receiver board_mic_checker i_mic_checker
(
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .sck          ( sck          ),
    .ws           ( ws           ),
    .sample_valid ( sample_valid )
);

/* board_specific_top.sv */
`timescale 1ns/100ps

module board_specific_top
    import board_pkg::*, audio_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1
)
(
    input  logic                    CLK,
    input  logic                    KEY,
    output logic                    LED,
    output logic [7:0]              ABCDEFGH_N,
    output logic [w_digit - 1:0]    DIGIT_N,
    inout  wire  [w_gpio + 3 - 1:3] GPIO_J12
);

    wire                  clk   = CLK;
    wire                  rst_n = KEY;   // button is already active low

    logic [7:0]           abcdefgh;
    logic [w_digit - 1:0] digit;
    logic                 slow_clk;
    logic [w_sample - 1:0] sample;
    logic                 sample_valid;

    assign ABCDEFGH_N = ~abcdefgh;
    assign DIGIT_N    = ~digit;

    slow_clk_gen
    #(
        .fast_clk_mhz ( clk_mhz     ),
        .slow_clk_hz  ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .slow_clk ( slow_clk )
    );

    lab_top i_lab_top
    (
        .clk          ( clk          ),
        .slow_clk     ( slow_clk     ),
        .rst_n        ( rst_n        ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .led          ( LED          ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk          ( clk                ),
        .rst_n        ( rst_n              ),
        .sck          ( GPIO_J12 [pin_sck] ),
        .ws           ( GPIO_J12 [pin_ws]  ),
        .lr           ( GPIO_J12 [pin_lr]  ),
        .sd           ( GPIO_J12 [pin_sd]  ),
        .sample       ( sample             ),
        .sample_valid ( sample_valid       )
    );

    assign GPIO_J12 [pin_vcc] = 1'b1;   // mic supply
    assign GPIO_J12 [pin_gnd] = 1'b0;

endmodule

/* lab_top.sv */
`timescale 1ns/100ps

module lab_top
    import board_pkg::*, audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  slow_clk,
    input  logic                  rst_n,
    input  logic [w_sample - 1:0] sample,
    input  logic                  sample_valid,
    output logic                  led,
    output logic [7:0]            abcdefgh,
    output logic [w_digit - 1:0]  digit
);

    logic [w_sample - 1:0] mag;
    logic [w_sample - 1:0] peak;       // running maximum of this window
    logic [w_sample - 1:0] disp_reg;   // peak of the last full window
    logic [w_meter - 1:0]  meter;
    logic                  slow_q;
    logic                  win_edge;

    // magnitude, the most negative word has no positive twin
    always_comb begin
        if (!sample[w_sample - 1])
            mag = sample;
        else if (sample == {1'b1, {(w_sample - 1){1'b0}}})
            mag = mag_max;
        else
            mag = -sample;
    end

    assign win_edge = slow_clk & ~slow_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slow_q   <= 1'b0;
            peak     <= '0;
            disp_reg <= '0;
        end else begin
            slow_q <= slow_clk;
            if (win_edge) begin
                disp_reg <= peak;
                peak     <= sample_valid ? mag : '0;   // this sample opens the new window
            end else if (sample_valid && mag > peak) begin
                peak <= mag;
            end
        end
    end

    assign meter = disp_reg[meter_msb:meter_lsb];
    assign led   = slow_clk;

    seven_segment_display i_display
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .number   ( meter    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

/* seven_segment_display.sv */
`timescale 1ns/100ps

module seven_segment_display
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [w_number - 1:0] number,
    output logic [7:0]            abcdefgh,
    output logic [w_digit - 1:0]  digit
);

    logic [w_scan_cnt - 1:0] scan_cnt;
    logic [3:0]              nibble;

    // one-hot scan, digit 0 first after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= w_digit'(1);
        end else if (scan_cnt == w_scan_cnt'(scan_cycles - 1)) begin
            scan_cnt <= '0;
            digit    <= {digit[w_digit - 2:0], digit[w_digit - 1]};   // next digit
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        nibble = '0;
        for (int i = 0; i < w_digit; i++)
            if (digit[i])
                nibble = number[i * 4 +: 4];
    end

    // segments a to g, h is the dot and stays dark
    always_comb begin
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;   // f
        endcase
    end

endmodule

/* inmp441_mic_i2s_receiver.sv */
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  sck,
    output logic                  ws,
    output logic                  lr,
    input  logic                  sd,
    output logic [w_sample - 1:0] sample,
    output logic                  sample_valid
);

    logic [w_sck_cnt - 1:0] sck_cnt;
    logic [w_bit_cnt - 1:0] bit_cnt;     // sck period within the frame
    logic                   sck_toggle;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   rise_q;      // sck went high last edge
    logic                   sd_q;
    logic                   lsb_q;       // left LSB now in shift_reg
    logic [w_sample - 1:0]  shift_reg;

    assign sck_toggle = (sck_cnt == w_sck_cnt'(sck_half - 1));
    assign sck_rise   = sck_toggle & ~sck;
    assign sck_fall   = sck_toggle &  sck;

    assign ws = (bit_cnt >= w_bit_cnt'(slot_bits));   // high in the right slot
    assign lr = 1'b0;                                 // mic answers in the left slot

    // bit clock and frame position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (sck_toggle) begin
                sck_cnt <= '0;
                sck     <= ~sck;
            end else begin
                sck_cnt <= sck_cnt + 1'b1;
            end

            if (sck_fall) begin
                if (bit_cnt == w_bit_cnt'(frame_bits - 1))
                    bit_cnt <= '0;
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rise_q       <= 1'b0;
            lsb_q        <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            rise_q       <= sck_rise;
            lsb_q        <= rise_q && !ws && (bit_cnt == w_bit_cnt'(w_sample));
            sample_valid <= lsb_q;
        end
    end

    // data path, MSB arrives in period 1 of the left slot
    always_ff @(posedge clk) begin
        sd_q <= sd;                          // sd as seen when sck rises
        if (rise_q)
            shift_reg <= {shift_reg[w_sample - 2:0], sd_q};
        if (lsb_q)
            sample <= shift_reg;
    end

endmodule

/* slow_clk_gen.sv */
`timescale 1ns/100ps

module slow_clk_gen
#(
    parameter int fast_clk_mhz = 50,
    parameter int slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic rst_n,
    output logic slow_clk
);

    // clk cycles per half period of slow_clk
    localparam int unsigned half_cycles = fast_clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam int w_cnt = half_cycles > 1 ? $clog2(half_cycles) : 1;

    logic [w_cnt - 1:0] cnt;
    logic               half_done;

    assign half_done = (cnt == w_cnt'(half_cycles - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (half_done) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;     // toggle every half period
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* audio_pkg.sv */
package audio_pkg;

    localparam int w_sample = 24;   // INMP441 word, two's complement

    // I2S bit clock, one sck period is 2 * sck_half clk cycles
    localparam int sck_half  = 4;
    localparam int w_sck_cnt = $clog2(sck_half);

    // frame of two slots, ws low for the left one
    localparam int slot_bits  = 32;
    localparam int frame_bits = 2 * slot_bits;
    localparam int w_bit_cnt  = $clog2(frame_bits);

    // magnitude bits that reach the display
    localparam int meter_msb = 22;
    localparam int meter_lsb = 11;
    localparam int w_meter   = meter_msb - meter_lsb + 1;

    localparam logic [w_sample - 1:0] mag_max = 24'h7fffff;   // clip for 800000

endpackage

/* board_pkg.sv */
package board_pkg;

    localparam int w_digit  = 3;             // display digits
    localparam int w_number = 4 * w_digit;   // hex value on the display
    localparam int w_gpio   = 36 - 3 + 1;    // GPIO_J12 pins 36 down to 3

    // INMP441 wiring on GPIO_J12
    localparam int pin_sd  = 3;
    localparam int pin_sck = 4;
    localparam int pin_vcc = 5;
    localparam int pin_ws  = 6;
    localparam int pin_gnd = 7;
    localparam int pin_lr  = 8;

    // display multiplexing
    localparam int scan_cycles = 16;                   // clk cycles per lit digit
    localparam int w_scan_cnt  = $clog2(scan_cycles);

endpackage
